/* delay_line.sv */
// Circular delay line, 256-word synchronous RAM with wrapping in and out pointers
`default_nettype none
`timescale 1ns/1ps
`include "lms_defs.svh"

module delay_line #(
	parameter int DEPTH = `LMS_DELAY_QUARTER
) (
	input  wire                   CLOCK_50,
	input  wire                   reset,
	input  wire                   rd_addr,      // Read phase, out pointer on the RAM
	input  wire                   capture,      // First write cycle
	input  wire                   write_hold,   // Second write cycle
	input  wire                   advance,      // Step both pointers
	input  wire lms_pkg::sample_t din,
	output lms_pkg::sample_t      dout,
	output logic                  wrapped
);
	import lms_pkg::*;

	localparam int    RAM_SIZE = 1 << `LMS_ADDR_W;
	localparam addr_t LAST     = addr_t'(DEPTH);   // Pointers run 0..DEPTH

	sample_t mem [RAM_SIZE];
	addr_t   ptr_in, ptr_out;
	addr_t   ram_addr;
	sample_t wr_data;     // Reference latched on capture
	sample_t ram_wdata;
	logic    ram_we;

	function automatic addr_t ptr_step(input addr_t p);
		return (p == LAST) ? '0 : p + 1'b1;
	endfunction

	// History starts silent
	initial
	begin
		for (int i = 0; i < RAM_SIZE; i++)
			mem[i] = '0;
	end

	assign ram_addr  = rd_addr ? ptr_out : ptr_in;
	assign ram_we    = capture | write_hold;
	assign ram_wdata = capture ? din : wr_data;   // Same word on both write cycles
	assign wrapped   = advance && (ptr_in == LAST);

	always_ff @(posedge CLOCK_50)
	begin
		if (ram_we)
			mem[ram_addr] <= ram_wdata;
		dout <= mem[ram_addr];   // Old word on a write cycle
		if (capture)
			wr_data <= din;
	end

	// Out pointer leads in pointer by one slot
	always_ff @(posedge CLOCK_50)
	begin
		if (reset)
		begin
			ptr_in  <= '0;
			ptr_out <= addr_t'(1);
		end
		else if (advance)
		begin
			ptr_in  <= ptr_step(ptr_in);
			ptr_out <= ptr_step(ptr_out);
		end
	end

	a_ptr_range: assert property (@(posedge CLOCK_50) disable iff (reset)
		(ptr_in <= LAST) && (ptr_out <= LAST));

endmodule

`default_nettype wire

/* lms_checker.sv */
// Bit-exact LMS reference model, output compare and out_valid timing checks
`default_nettype none
`timescale 1ns/1ps
`include "lms_defs.svh"

module lms_checker (
	input  wire                        CLOCK_50,
	input  wire                        reset,
	input  wire                        lrck,
	input  wire lms_pkg::sample_pair_t samples_in,
	input  wire lms_pkg::audio_out_t   samples_out,
	input  wire                        out_valid,
	output int                         error_count,
	output int                         start_count,   // Frame starts seen on lrck
	output int                         valid_count    // out_valid pulses
);
	import lms_pkg::*;

	sample_t    ref_hist [256];   // Reference by frame number mod 256
	work_t      w [4];            // Model weights
	int         frame_n;          // Frames since reset
	int         out_n;            // Outputs since reset
	logic       lrck_prev;
	logic       after_reset;
	logic [4:0] valid_pipe;       // Frame starts delayed by 5 cycles
	audio_out_t expect_q [$];
	logic       frame_start;

	initial
	begin
		error_count = 0;
		start_count = 0;
		valid_count = 0;
	end

	assign frame_start = lrck && !lrck_prev;

	function automatic sample_t delayed_ref(input int depth);
		if (frame_n < depth)
			return '0;   // Line still silent
		return ref_hist[(frame_n - depth) % 256];
	endfunction

	//////////////////////////////////////////////////////////////////////
	// One canceller frame with outputs from the old weights
	//////////////////////////////////////////////////////////////////////
	task automatic model_frame(input sample_pair_t s);
		work_t              x [4];
		work_t              acc;
		work_t              err;
		work_t              e_dir;
		logic signed [35:0] full;
		audio_out_t         exp_out;
		x[0] = {s.ref_in, 2'b00};
		x[1] = {delayed_ref(`LMS_DELAY_QUARTER), 2'b00};
		x[2] = {delayed_ref(`LMS_DELAY_SIXTH), 2'b00};
		x[3] = {delayed_ref(`LMS_DELAY_TWELFTH), 2'b00};
		acc = '0;
		for (int i = 0; i < 4; i++)
		begin
			full = w[i] * x[i];
			acc  = acc + {full[35], full[32:16]};   // Sign plus bits 32..16
		end
		err           = {s.noisy_in, 2'b00} - acc;
		exp_out.clean = -err[17:2];
		exp_out.raw   = -s.noisy_in;
		expect_q.push_back(exp_out);
		// Quarter pointers run 0..200, so the wrap follows frame 200
		if (frame_n > `LMS_DELAY_QUARTER)
		begin
			for (int i = 0; i < 4; i++)
			begin
				e_dir = x[i][17] ? -err : err;
				w[i]  = w[i] + (e_dir >>> `LMS_MU_SHIFT);
			end
		end
		ref_hist[frame_n % 256] = s.ref_in;
		frame_n++;
	endtask

	task automatic check_output();
		audio_out_t exp_out;
		valid_count++;
		out_n++;
		if (expect_q.size() == 0)
		begin
			$display("out_valid at %0t arrived with no frame waiting for it", $time);
			error_count++;
		end
		else
		begin
			exp_out = expect_q.pop_front();
			if (samples_out.raw !== exp_out.raw)
			begin
				$display("error %0t: raw %0d, expected %0d", $time,
					samples_out.raw, exp_out.raw);
				error_count++;
			end
			if (samples_out.clean !== exp_out.clean)
			begin
				$display("error %0t: clean %0d, expected %0d", $time,
					samples_out.clean, exp_out.clean);
				error_count++;
			end
			// Frames 0..201 see zero weights
			if (out_n <= `LMS_DELAY_QUARTER + 2 && samples_out.clean !== exp_out.raw)
			begin
				$display("error %0t: clean %0d differs from raw %0d before buffer full",
					$time, samples_out.clean, exp_out.raw);
				error_count++;
			end
		end
	endtask

	always @(posedge CLOCK_50)
	begin
		if (reset)
		begin
			frame_n = 0;   // History and weights restart
			out_n   = 0;
			for (int i = 0; i < 4; i++)
				w[i] = '0;
			expect_q.delete();
			lrck_prev   <= 1'b1;   // DUT needs lrck low first
			valid_pipe  <= '0;
			after_reset <= 1'b1;
		end
		else
		begin
			if (after_reset && (samples_out !== '0 || out_valid !== 1'b0))
			begin
				$display("error %0t: outputs not cleared by reset", $time);
				error_count++;
			end
			if (out_valid !== valid_pipe[4])
			begin
				$display("error %0t: out_valid %b, expected %b", $time, out_valid, valid_pipe[4]);
				error_count++;
			end
			if (out_valid === 1'b1)
				check_output();
			if (frame_start)
			begin
				start_count++;
				model_frame(samples_in);
			end
			after_reset <= 1'b0;
			lrck_prev   <= lrck;
			valid_pipe  <= {valid_pipe[3:0], frame_start};
		end
	end

endmodule

`default_nettype wire

/* lms_datapath.sv */
// Four-tap sign-data LMS datapath with tap, weight and output registers
`default_nettype none
`timescale 1ns/1ps
`include "lms_defs.svh"

module lms_datapath (
	input  wire                        CLOCK_50,
	input  wire                        reset,
	input  wire                        capture,       // Latch taps and noisy sample
	input  wire                        update,        // Register outputs
	input  wire                        weight_load,   // Store new weights
	input  wire lms_pkg::sample_pair_t samples_in,
	input  wire lms_pkg::taps_t        delayed,       // x1..x3 from the delay lines
	output lms_pkg::audio_out_t        samples_out
);
	import lms_pkg::*;

	localparam int NTAPS = 4;

	taps_t   taps;           // Taps for this frame
	sample_t noisy_q;        // Noisy sample for this frame
	work_t   tap_x  [NTAPS];
	work_t   weight [NTAPS];
	work_t   prod   [NTAPS];
	work_t   step   [NTAPS];
	work_t   w_next [NTAPS];
	work_t   noisy_x;
	work_t   tap_sum;
	work_t   error;

	// 2.16 multiply, sign bit kept and top integer bits dropped
	function automatic work_t fx_mult(input work_t a, input work_t b);
		logic signed [2*`LMS_WORK_W-1:0] full;
		full = a * b;
		return {full[2*`LMS_WORK_W-1], full[2*`LMS_WORK_W-4:`LMS_WORK_W-2]};
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Tap capture
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge CLOCK_50)
	begin
		if (capture)
		begin
			taps.x0 <= {samples_in.ref_in, 2'b00};   // Current reference
			taps.x1 <= delayed.x1;
			taps.x2 <= delayed.x2;
			taps.x3 <= delayed.x3;
			noisy_q <= samples_in.noisy_in;
		end
	end

	assign tap_x[0] = taps.x0;
	assign tap_x[1] = taps.x1;
	assign tap_x[2] = taps.x2;
	assign tap_x[3] = taps.x3;

	//////////////////////////////////////////////////////////////////////
	// Filter, error and sign-data update
	//////////////////////////////////////////////////////////////////////
	for (genvar i = 0; i < NTAPS; i++)
	begin : g_tap
		assign prod[i] = fx_mult(weight[i], tap_x[i]);
		// Error steered by tap sign, scaled by mu
		assign step[i]   = (tap_x[i][`LMS_WORK_W-1] ? -error : error) >>> `LMS_MU_SHIFT;
		assign w_next[i] = weight[i] + step[i];
	end

	assign noisy_x = {noisy_q, 2'b00};
	assign tap_sum = prod[0] + prod[1] + prod[2] + prod[3];   // Wraps in 18 bits
	assign error   = noisy_x - tap_sum;

	// Weights frozen until the sequencer allows loading
	always_ff @(posedge CLOCK_50)
	begin
		if (reset)
		begin
			for (int i = 0; i < NTAPS; i++)
				weight[i] <= '0;
		end
		else if (weight_load)
		begin
			for (int i = 0; i < NTAPS; i++)
				weight[i] <= w_next[i];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Output register
	//////////////////////////////////////////////////////////////////////
	// Codec inverts, so both channels go out negated
	always_ff @(posedge CLOCK_50)
	begin
		if (reset)
			samples_out <= '0;
		else if (update)
		begin
			samples_out.clean <= -error[`LMS_WORK_W-1:2];   // Drop fraction extension
			samples_out.raw   <= -noisy_q;
		end
	end

	a_out_known: assert property (@(posedge CLOCK_50) disable iff (reset)
		!$isunknown(samples_out));

endmodule

`default_nettype wire

/* lms_defs.svh */
// Width, delay length and step size macros for the LMS noise canceller
`ifndef LMS_DEFS_SVH
`define LMS_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// Datapath widths
//////////////////////////////////////////////////////////////////////
`define LMS_SAMPLE_W 16   // Codec sample
`define LMS_WORK_W   18   // 2.16 fixed point
`define LMS_ADDR_W   8    // Delay RAM address, 256 words

//////////////////////////////////////////////////////////////////////
// Delay line lengths in frames
//////////////////////////////////////////////////////////////////////
// One 60 Hz period is 800 frames at 48 kHz
`define LMS_DELAY_QUARTER 200   // 90 degrees of the fundamental
`define LMS_DELAY_SIXTH   133   // 60 degrees
`define LMS_DELAY_TWELFTH 67    // 30 degrees

// Adaptation step, mu = 2^-10
`define LMS_MU_SHIFT 10

`endif

/* lms_pkg.sv */
// Sample, 2.16 work word and address types, sample and tap structs, sequencer states
`default_nettype none
`include "lms_defs.svh"

package lms_pkg;

	//////////////////////////////////////////////////////////////////////
	// Scalar types
	//////////////////////////////////////////////////////////////////////
	typedef logic signed [`LMS_SAMPLE_W-1:0] sample_t;   // Codec sample
	typedef logic signed [`LMS_WORK_W-1:0]   work_t;     // Taps, products, error, weights
	typedef logic [`LMS_ADDR_W-1:0]          addr_t;     // Delay RAM address

	// Per-frame input pair
	typedef struct packed {
		sample_t ref_in;     // Line noise reference
		sample_t noisy_in;   // Signal plus noise
	} sample_pair_t;

	// Output pair to the DAC
	typedef struct packed {
		sample_t clean;   // Negated error
		sample_t raw;     // Negated noisy input
	} audio_out_t;

	// Four filter taps
	typedef struct packed {
		work_t x0;   // Current reference
		work_t x1;   // Quarter delay
		work_t x2;   // Sixth delay
		work_t x3;   // Twelfth delay
	} taps_t;

	// Per-frame sequencer
	typedef enum logic [2:0] {
		s_wait,
		s_read,
		s_capture,
		s_write_hold,
		s_update,
		s_advance
	} seq_state_t;

endpackage

`default_nettype wire

/* noise_canceller.sv */
// Top level of the 60 Hz canceller, three delay lines, sequencer and LMS datapath
`default_nettype none
`timescale 1ns/1ps
`include "lms_defs.svh"

module noise_canceller (
	input  wire                        CLOCK_50,
	input  wire                        reset,
	input  wire                        lrck,         // Frame level
	input  wire lms_pkg::sample_pair_t samples_in,   // Stable until out_valid
	output lms_pkg::audio_out_t        samples_out,
	output logic                       out_valid
);
	import lms_pkg::*;

	logic    rd_addr, capture, write_hold, update, advance;
	logic    weight_load;
	logic    tap_wrapped;   // Quarter line wrap
	sample_t dly_quarter, dly_sixth, dly_twelfth;
	taps_t   delayed;

	//////////////////////////////////////////////////////////////////////
	// Delay lines fed with the reference
	//////////////////////////////////////////////////////////////////////
	delay_line #(.DEPTH(`LMS_DELAY_QUARTER)) u_quarter (
		.CLOCK_50   (CLOCK_50),
		.reset      (reset),
		.rd_addr    (rd_addr),
		.capture    (capture),
		.write_hold (write_hold),
		.advance    (advance),
		.din        (samples_in.ref_in),
		.dout       (dly_quarter),
		.wrapped    (tap_wrapped)   // Drives the weight interlock
	);

	delay_line #(.DEPTH(`LMS_DELAY_SIXTH)) u_sixth (
		.CLOCK_50   (CLOCK_50),
		.reset      (reset),
		.rd_addr    (rd_addr),
		.capture    (capture),
		.write_hold (write_hold),
		.advance    (advance),
		.din        (samples_in.ref_in),
		.dout       (dly_sixth),
		.wrapped    ()
	);

	delay_line #(.DEPTH(`LMS_DELAY_TWELFTH)) u_twelfth (
		.CLOCK_50   (CLOCK_50),
		.reset      (reset),
		.rd_addr    (rd_addr),
		.capture    (capture),
		.write_hold (write_hold),
		.advance    (advance),
		.din        (samples_in.ref_in),
		.dout       (dly_twelfth),
		.wrapped    ()
	);

	// Delayed taps in 2.16, current tap formed inside the datapath
	assign delayed.x0 = '0;
	assign delayed.x1 = {dly_quarter, 2'b00};
	assign delayed.x2 = {dly_sixth, 2'b00};
	assign delayed.x3 = {dly_twelfth, 2'b00};

	sample_sequencer u_seq (
		.CLOCK_50    (CLOCK_50),
		.reset       (reset),
		.lrck        (lrck),
		.tap_wrapped (tap_wrapped),
		.rd_addr     (rd_addr),
		.capture     (capture),
		.write_hold  (write_hold),
		.update      (update),
		.weight_load (weight_load),
		.advance     (advance),
		.out_valid   (out_valid)
	);

	lms_datapath u_dp (
		.CLOCK_50    (CLOCK_50),
		.reset       (reset),
		.capture     (capture),
		.update      (update),
		.weight_load (weight_load),
		.samples_in  (samples_in),
		.delayed     (delayed),
		.samples_out (samples_out)
	);

endmodule

`default_nettype wire

/* sample_sequencer.sv */
// Frame one-shot, per-frame sequencing FSM and buffer-full weight interlock
`default_nettype none
`timescale 1ns/1ps

module sample_sequencer (
	input  wire  CLOCK_50,
	input  wire  reset,
	input  wire  lrck,          // Frame level
	input  wire  tap_wrapped,   // Quarter line in pointer wrapped
	output logic rd_addr,
	output logic capture,
	output logic write_hold,
	output logic update,
	output logic weight_load,
	output logic advance,
	output logic out_valid
);
	import lms_pkg::*;

	seq_state_t state, state_next;
	logic       lrck_q;         // Last lrck sample
	logic       frame_start;
	logic       buffer_full;    // Longest history filled once

	// Rising lrck seen on the clock
	assign frame_start = lrck && !lrck_q;

	always_ff @(posedge CLOCK_50)
	begin
		if (reset)
		begin
			state       <= s_wait;
			lrck_q      <= 1'b1;   // Need lrck low before the first frame
			buffer_full <= 1'b0;
			out_valid   <= 1'b0;
		end
		else
		begin
			state     <= state_next;
			lrck_q    <= lrck;
			out_valid <= update;   // Outputs registered on update
			if (tap_wrapped)
				buffer_full <= 1'b1;   // Held until reset
		end
	end

	//////////////////////////////////////////////////////////////////////
	// One pass per frame
	//////////////////////////////////////////////////////////////////////
	always_comb
	begin
		state_next = state;
		case (state)
			s_wait:       if (frame_start) state_next = s_read;
			s_read:       state_next = s_capture;
			s_capture:    state_next = s_write_hold;
			s_write_hold: state_next = s_update;
			s_update:     state_next = s_advance;
			s_advance:    state_next = s_wait;
			default:      state_next = s_wait;
		endcase
	end

	assign rd_addr     = (state == s_read);
	assign capture     = (state == s_capture);
	assign write_hold  = (state == s_write_hold);
	assign update      = (state == s_update);
	assign advance     = (state == s_advance);
	assign weight_load = update && buffer_full;   // Adapt only on full history

	// Quarter line wraps only on the pointer step
	a_wrap_on_advance: assert property (@(posedge CLOCK_50) disable iff (reset)
		tap_wrapped |-> advance);

	a_frame_idle: assert property (@(posedge CLOCK_50) disable iff (reset)
		frame_start |-> state == s_wait);

endmodule

`default_nettype wire

/* tb_noise_canceller.sv */
// Testbench top for the noise canceller with clock, reset, LFSR stimulus, timeout and report
`default_nettype none
`timescale 1ns/1ps

module tb_noise_canceller;
	import lms_pkg::*;

	localparam int N_FRAMES       = 700;
	localparam int FRAME_CYCLES   = 32;    // lrck period
	localparam int SINE_FRAME     = 300;   // Sine reference from here on
	localparam int RESET_FRAME    = 420;   // Mid-run reset
	localparam int TIMEOUT_CYCLES = N_FRAMES * FRAME_CYCLES + 2000;

	logic         CLOCK_50 = 1'b0;
	logic         reset;
	logic         lrck;
	sample_pair_t samples_in;
	audio_out_t   samples_out;
	logic         out_valid;
	logic [31:0]  lfsr_state = 32'h8316bb36;
	int           cycle_count = 0;
	int           error_count, start_count, valid_count;

	always #5 CLOCK_50 = ~CLOCK_50;   // 10 ns period

	noise_canceller i_dut (
		.CLOCK_50    (CLOCK_50),
		.reset       (reset),
		.lrck        (lrck),
		.samples_in  (samples_in),
		.samples_out (samples_out),
		.out_valid   (out_valid)
	);

	lms_checker i_checker (
		.CLOCK_50    (CLOCK_50),
		.reset       (reset),
		.lrck        (lrck),
		.samples_in  (samples_in),
		.samples_out (samples_out),
		.out_valid   (out_valid),
		.error_count (error_count),
		.start_count (start_count),
		.valid_count (valid_count)
	);

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] bits);
		bits = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			bits       = {bits[30:0], lfsr_state[0]};   // One step per bit
		end
	endtask

	// Coarse sine, 16 steps per period
	function automatic sample_t sine_step(input int idx);
		sample_t mag;
		case (idx % 8)
			0:       mag = 16'sd0;
			1, 7:    mag = 16'sd4592;
			2, 6:    mag = 16'sd8485;
			3, 5:    mag = 16'sd11086;
			default: mag = 16'sd12000;
		endcase
		return (idx % 16 >= 8) ? -mag : mag;
	endfunction

	task automatic apply_reset();
		@(posedge CLOCK_50);
		reset <= 1'b1;
		repeat (2) @(posedge CLOCK_50);
		reset <= 1'b0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Frame stimulus
	//////////////////////////////////////////////////////////////////////
	initial
	begin
		sample_pair_t pair;
		logic [31:0]  bits;
		sample_t      ref_bits, noisy_bits, wave;
		int           high_cycles, gain_shift, count_errors;
		reset      <= 1'b1;
		lrck       <= 1'b0;
		samples_in <= '0;
		repeat (2) @(posedge CLOCK_50);
		reset <= 1'b0;
		take_bits(2, bits);
		gain_shift = bits[1:0];   // Reference gain for the sine frames
		for (int frame = 0; frame < N_FRAMES; frame++)
		begin
			if (frame == RESET_FRAME)
				apply_reset();
			take_bits(5, bits);
			high_cycles = 4 + bits % 25;   // 4..28 cycles high
			take_bits(16, bits);
			ref_bits = bits[15:0];
			take_bits(16, bits);
			noisy_bits = bits[15:0];
			if (frame < SINE_FRAME)
			begin
				pair.ref_in   = ref_bits;
				pair.noisy_in = noisy_bits;
			end
			else
			begin
				wave          = sine_step(frame / 50);   // 800 frames per period
				pair.ref_in   = (wave >>> gain_shift) + (ref_bits >>> 12);
				pair.noisy_in = wave + (noisy_bits >>> 4);
			end
			@(posedge CLOCK_50);
			lrck       <= 1'b1;
			samples_in <= pair;   // Held until the next frame
			repeat (high_cycles) @(posedge CLOCK_50);
			lrck <= 1'b0;
			repeat (FRAME_CYCLES - high_cycles - 1) @(posedge CLOCK_50);
		end
		while (valid_count < start_count)
			@(posedge CLOCK_50);
		count_errors = 0;
		if (start_count != N_FRAMES || valid_count != start_count)
		begin
			$display("Frame count mismatch, %0d frames driven, %0d starts, %0d outputs",
				N_FRAMES, start_count, valid_count);
			count_errors++;
		end
		$display("Errors: %0d value, %0d count over %0d frames", error_count, count_errors,
			start_count);
		if (error_count == 0 && count_errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	always @(posedge CLOCK_50)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("Run stopped after %0d cycles without finishing", cycle_count);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+.
lms_pkg.sv
delay_line.sv
lms_datapath.sv
sample_sequencer.sv
noise_canceller.sv
lms_checker.sv
tb_noise_canceller.sv
